// ==== vlog.f ====
rtl/console_pkg.sv
rtl/apb_if.sv
rtl/ps2_receiver.sv
rtl/scan_decoder.sv
rtl/key_bus_master.sv
rtl/peripheral_bus.sv
rtl/uart_tx.sv
rtl/keyboard_console.sv
bench/keyboard_console_properties.sv
bench/tb_keyboard_console.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_keyboard_console
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_keyboard_console.sv ====
module tb_keyboard_console;

    localparam int CLKS_PER_BIT   = 16;
    localparam int FIFO_DEPTH     = 4;
    // ps/2 half period in system clocks
    localparam int HALF_PERIOD    = 4;
    localparam int ROUNDS         = 50;
    localparam int BURSTS         = 3;
    localparam int TIMEOUT_CYCLES = 200 * 400;
    localparam int DRAIN_LIMIT    = (FIFO_DEPTH + 2) * 10 * CLKS_PER_BIT + 200;
    localparam int NUM_KEYS       = 38;

    // set 2 codes and their characters, same order, enter last
    localparam logic [8*NUM_KEYS-1:0] KEY_CODES = {
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A, 8'h45, 8'h16, 8'h1E, 8'h26,
        8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h29, 8'h5A
    };
    localparam logic [8*NUM_KEYS-1:0] KEY_CHARS = {
        "abcdefghijklmnopqrstuvwxyz0123456789 ", 8'h0D
    };

    logic        CLOCK_50;
    logic        reset;
    logic        ps2_clk;
    logic        ps2_dat;
    logic        uart_txd;
    logic [7:0]  ledg;

    logic [31:0] rng;
    logic [7:0]  exp_q [$];
    logic [7:0]  last_key;
    logic        brk_flag;
    logic        ext_flag;
    int          value_errors;
    int          other_errors;
    int          cycle_count;

    keyboard_console #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) i_keyboard_console (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .uart_txd (uart_txd),
        .ledg     (ledg)
    );

    always #50 CLOCK_50 = ~CLOCK_50;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // reference key table lookup, 0 when unmapped
    function automatic logic [7:0] model_ascii(input logic [7:0] code);
        logic [7:0] result;
        result = 8'h00;
        for (int i = 0; i < NUM_KEYS; i++) begin
            if (KEY_CODES[8*(NUM_KEYS-1-i) +: 8] == code) begin
                result = KEY_CHARS[8*(NUM_KEYS-1-i) +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [7:0] random_key();
        logic [31:0] r;
        int          idx;
        r   = next_rand();
        idx = int'(r % 32'd38);
        return KEY_CODES[8*idx +: 8];
    endfunction

    // any code that maps to nothing and is no prefix
    function automatic logic [7:0] random_unmapped();
        logic [31:0] r;
        logic [7:0]  code;
        r    = next_rand();
        code = r[7:0];
        while (model_ascii(code) != 8'h00 || code == 8'hF0 || code == 8'hE0) begin
            code = code + 8'd1;
        end
        return code;
    endfunction

    // ledg holds this char or a later one still in flight
    function automatic logic led_plausible(input logic [7:0] ch);
        logic found;
        found = (ledg == ch);
        foreach (exp_q[i]) begin
            if (exp_q[i] == ledg) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // inputs change a little after the rising edge
    task automatic wait_clocks(input int n);
        repeat (n) @(posedge CLOCK_50);
        #10;
    endtask

    // prefix rules of the keyboard side
    task automatic model_scan(input logic [7:0] code);
        logic [7:0] ch;
        if (code == 8'hF0) begin
            brk_flag = 1'b1;
        end else if (code == 8'hE0) begin
            ext_flag = 1'b1;
        end else begin
            ch = model_ascii(code);
            if (!brk_flag && !ext_flag && ch != 8'h00) begin
                exp_q.push_back(ch);
                last_key = ch;
            end
            brk_flag = 1'b0;
            ext_flag = 1'b0;
        end
    endtask

    // start, 8 data lsb first, odd parity, stop
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_dat = bits[i];
            wait_clocks(HALF_PERIOD);
            ps2_clk = 1'b0;
            // model sees the code before the dut can act on it
            if (i == 10 && !bad_parity) begin
                model_scan(code);
            end
            wait_clocks(HALF_PERIOD);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        wait_clocks(2 * HALF_PERIOD);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            wait_clocks(1);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected characters never arrived on uart_txd", exp_q.size());
            other_errors++;
            exp_q.delete();
        end
        if (ledg !== last_key) begin
            $display("FAIL at %0t: ledg %h after drain, expected %h", $time, ledg, last_key);
            value_errors++;
        end
    endtask

    // 8n1 receiver, sampled mid bit on the falling clock
    task automatic receive_char();
        logic [7:0] rx_byte;
        logic [7:0] expected;
        repeat (CLKS_PER_BIT / 2) @(negedge CLOCK_50);
        if (uart_txd !== 1'b0) begin
            $display("start bit on uart_txd too short at %0t", $time);
            other_errors++;
            return;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
            rx_byte[i] = uart_txd;
        end
        repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
        if (uart_txd !== 1'b1) begin
            $display("FAIL at %0t: stop bit %b on uart_txd", $time, uart_txd);
            value_errors++;
        end
        if (exp_q.size() == 0) begin
            $display("unexpected character %h appeared on uart_txd", rx_byte);
            other_errors++;
        end else begin
            expected = exp_q.pop_front();
            if (rx_byte !== expected) begin
                $display("FAIL at %0t: uart char %h, expected %h", $time, rx_byte, expected);
                value_errors++;
            end
            if (!led_plausible(expected)) begin
                $display("FAIL at %0t: ledg %h behind uart char %h", $time, ledg, expected);
                value_errors++;
            end
        end
    endtask

    always @(negedge CLOCK_50) begin
        if (!reset && uart_txd === 1'b0) begin
            receive_char();
        end
    end

    // hard stop on a hung run
    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d characters outstanding",
                     cycle_count, exp_q.size());
            $display("errors: %0d wrong values, %0d other failures", value_errors,
                     other_errors);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        CLOCK_50     = 1'b0;
        reset        = 1'b1;
        ps2_clk      = 1'b1;
        ps2_dat      = 1'b1;
        rng          = 32'h7628dd0f;
        last_key     = 8'h00;
        brk_flag     = 1'b0;
        ext_flag     = 1'b0;
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        wait_clocks(16);
        reset = 1'b0;
        wait_clocks(4);

        // mixed traffic, at most one character per round
        for (int round = 0; round < ROUNDS; round++) begin
            r = next_rand();
            case (r[2:0])
                3'd3: begin
                    send_frame(8'hF0, 1'b0);
                    send_frame(random_key(), 1'b0);
                end
                3'd4: begin
                    send_frame(8'hE0, 1'b0);
                    send_frame(random_key(), 1'b0);
                end
                3'd5: begin
                    send_frame(random_unmapped(), 1'b0);
                    send_frame(random_key(), 1'b0);
                end
                3'd6: begin
                    // corrupted frame then a good key
                    send_frame(random_key(), 1'b1);
                    send_frame(random_key(), 1'b0);
                end
                3'd7: begin
                    // press and release
                    send_frame(random_key(), 1'b0);
                    send_frame(8'hF0, 1'b0);
                    send_frame(random_key(), 1'b0);
                end
                default: send_frame(random_key(), 1'b0);
            endcase
            if (exp_q.size() >= FIFO_DEPTH) begin
                drain();
            end
        end
        drain();

        // back to back keys against the fifo
        for (int b = 0; b < BURSTS; b++) begin
            for (int k = 0; k < FIFO_DEPTH + 1; k++) begin
                send_frame(random_key(), 1'b0);
            end
            drain();
        end

        wait_clocks(20 * CLKS_PER_BIT);
        if (exp_q.size() != 0) begin
            $display("%0d expected characters still missing at the end", exp_q.size());
            other_errors++;
        end
        if (uart_txd !== 1'b1) begin
            $display("uart_txd is not idle high at the end of the run");
            other_errors++;
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== bench/keyboard_console_properties.sv ====
module keyboard_console_properties (
    input logic                   CLOCK_50,
    input logic                   reset,
    input logic                   psel,
    input logic                   penable,
    input logic                   pready,
    input console_pkg::apb_addr_t paddr,
    input console_pkg::apb_data_t pwdata
);

    // access phase only entered straight from a setup cycle
    enable_after_setup: assert property (@(posedge CLOCK_50) disable iff (reset)
        $rose(penable) |-> (psel && $past(psel)))
        else $error("penable rose without a preceding setup cycle");

    // address and write data frozen until the transfer completes
    stable_during_transfer: assert property (@(posedge CLOCK_50) disable iff (reset)
        (psel && !(penable && pready)) |=> ($stable(paddr) && $stable(pwdata)))
        else $error("paddr or pwdata changed inside a transfer");

    // every slave here answers in its first access cycle
    // and the master leaves access right after
    ready_in_first_access: assert property (@(posedge CLOCK_50) disable iff (reset)
        (psel && penable) |-> (pready ##1 !penable))
        else $error("access phase did not complete in one cycle");

endmodule

// master side, between the key master and the decoder
bind key_bus_master keyboard_console_properties i_master_props (
    .CLOCK_50 (CLOCK_50),
    .reset    (reset),
    .psel     (bus.psel),
    .penable  (bus.penable),
    .pready   (bus.pready),
    .paddr    (bus.paddr),
    .pwdata   (bus.pwdata)
);

// uart side, after the decoder gates psel
bind uart_tx keyboard_console_properties i_uart_props (
    .CLOCK_50 (CLOCK_50),
    .reset    (reset),
    .psel     (bus.psel),
    .penable  (bus.penable),
    .pready   (bus.pready),
    .paddr    (bus.paddr),
    .pwdata   (bus.pwdata)
);

// ==== rtl/keyboard_console.sv ====
module keyboard_console #(
    parameter int CLKS_PER_BIT = 434,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic       uart_txd,
    output logic [7:0] ledg
);

    console_pkg::scan_t  scan;
    logic                scan_valid;
    console_pkg::ascii_t char;
    logic                char_valid;

    // master to decoder, decoder to uart
    apb_if host_bus ();
    apb_if uart_bus ();

    ps2_receiver i_ps2_receiver (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .scan       (scan),
        .scan_valid (scan_valid)
    );

    scan_decoder i_scan_decoder (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .scan       (scan),
        .scan_valid (scan_valid),
        .char       (char),
        .char_valid (char_valid)
    );

    // stands in for the cpu as bus initiator
    key_bus_master i_key_bus_master (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .char       (char),
        .char_valid (char_valid),
        .bus        (host_bus.master)
    );

    peripheral_bus i_peripheral_bus (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .up       (host_bus.slave),
        .uart     (uart_bus.master),
        .ledg     (ledg)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) i_uart_tx (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .bus      (uart_bus.slave),
        .txd      (uart_txd)
    );

endmodule

// ==== rtl/uart_tx.sv ====
module uart_tx #(
    parameter int CLKS_PER_BIT = 434,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic CLOCK_50,
    input  logic reset,
    apb_if.slave bus,
    output logic txd
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(CLKS_PER_BIT - 1);

    // circular fifo, pointers carry one wrap bit
    console_pkg::ascii_t mem [FIFO_DEPTH];
    logic [PTR_W:0]      wr_ptr;
    logic [PTR_W:0]      rd_ptr;
    logic                fifo_full;
    logic                fifo_empty;
    logic                push;
    logic                pop;
    logic                stat_sel;
    logic                data_sel;
    // serializer
    logic                tx_active;
    logic [9:0]          shifter;
    logic [3:0]          bit_cnt;
    logic [CNT_W-1:0]    clk_cnt;
    logic                busy;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                        (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign busy       = tx_active | ~fifo_empty;

    assign stat_sel = (bus.paddr == console_pkg::UART_STAT_ADDR);
    assign data_sel = (bus.paddr == console_pkg::UART_DATA_ADDR);

    // apb response, always zero wait states
    assign bus.pready  = 1'b1;
    // status is read only
    assign bus.pslverr = bus.psel & bus.penable & bus.pwrite & stat_sel;
    assign bus.prdata  = stat_sel ? {30'h0, busy, fifo_full} : 32'h00000000;

    // writes into a full fifo are dropped
    assign push = bus.psel & bus.penable & bus.pwrite & data_sel & ~fifo_full;
    assign pop  = ~tx_active & ~fifo_empty;

    always_ff @(posedge CLOCK_50) begin
        if (push) begin
            mem[wr_ptr[PTR_W-1:0]] <= bus.pwdata[7:0];
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            tx_active <= 1'b0;
            bit_cnt   <= 4'd0;
            clk_cnt   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr    <= rd_ptr + 1'b1;
                tx_active <= 1'b1;
                bit_cnt   <= 4'd0;
                clk_cnt   <= '0;
            end else if (tx_active) begin
                if (clk_cnt == LAST_TICK) begin
                    clk_cnt <= '0;
                    // stop bit done after ten bit times
                    if (bit_cnt == 4'd9) begin
                        tx_active <= 1'b0;
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
            end
        end
    end

    // stop, data lsb first, start in bit 0
    always_ff @(posedge CLOCK_50) begin
        if (pop) begin
            shifter <= {1'b1, mem[rd_ptr[PTR_W-1:0]], 1'b0};
        end else if (tx_active && clk_cnt == LAST_TICK) begin
            shifter <= {1'b1, shifter[9:1]};
        end
    end

    // line idles high
    assign txd = tx_active ? shifter[0] : 1'b1;

endmodule

// ==== rtl/peripheral_bus.sv ====
module peripheral_bus (
    input  logic                CLOCK_50,
    input  logic                reset,
    apb_if.slave                up,
    apb_if.master               uart,
    output console_pkg::ascii_t ledg
);

    logic                led_sel;
    logic                uart_sel;
    logic                led_write;
    console_pkg::ascii_t led_reg;

    // address decode
    assign led_sel  = (up.paddr == console_pkg::LED_ADDR);
    assign uart_sel = (up.paddr == console_pkg::UART_DATA_ADDR) ||
                      (up.paddr == console_pkg::UART_STAT_ADDR);

    // uart side sees only its own addresses
    assign uart.paddr   = up.paddr;
    assign uart.psel    = up.psel & uart_sel;
    assign uart.penable = up.penable & uart_sel;
    assign uart.pwrite  = up.pwrite;
    assign uart.pwdata  = up.pwdata;

    // response mux, local targets answer at once
    assign up.pready  = uart_sel ? uart.pready : 1'b1;
    assign up.pslverr = uart_sel ? uart.pslverr : ~led_sel;
    assign up.prdata  = uart_sel ? uart.prdata :
                        led_sel  ? {24'h000000, led_reg} : 32'h00000000;

    // led register
    assign led_write = up.psel & up.penable & up.pwrite & led_sel;

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            led_reg <= 8'h00;
        end else if (led_write) begin
            led_reg <= up.pwdata[7:0];
        end
    end

    assign ledg = led_reg;

endmodule

// ==== rtl/key_bus_master.sv ====
module key_bus_master (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  console_pkg::ascii_t char,
    input  logic                char_valid,
    apb_if.master               bus
);

    // single entry holding buffer
    logic                       pending_valid;
    console_pkg::ascii_t        pending_char;
    console_pkg::master_state_t state;
    console_pkg::master_state_t state_next;
    logic                       xfer_done;
    logic                       release_char;
    logic                       capture;

    assign xfer_done = bus.psel & bus.penable & bus.pready;

    // done after the uart write, or abandoned on a bus error
    assign release_char = xfer_done &
                          ((state == console_pkg::UART_ACCESS) | bus.pslverr);

    // keys arriving while busy are lost
    assign capture = char_valid & ~pending_valid;

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            pending_valid <= 1'b0;
            state         <= console_pkg::IDLE;
        end else begin
            state <= state_next;
            if (release_char) begin
                pending_valid <= 1'b0;
            end else if (capture) begin
                pending_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (capture) begin
            pending_char <= char;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            console_pkg::IDLE: begin
                if (pending_valid) begin
                    state_next = console_pkg::POLL_SETUP;
                end
            end
            console_pkg::POLL_SETUP:  state_next = console_pkg::POLL_ACCESS;
            console_pkg::POLL_ACCESS: begin
                if (bus.pready) begin
                    if (bus.pslverr) begin
                        state_next = console_pkg::IDLE;
                    end else if (bus.prdata[0]) begin
                        // fifo full, poll again
                        state_next = console_pkg::POLL_SETUP;
                    end else begin
                        state_next = console_pkg::LED_SETUP;
                    end
                end
            end
            console_pkg::LED_SETUP:   state_next = console_pkg::LED_ACCESS;
            console_pkg::LED_ACCESS: begin
                if (bus.pready) begin
                    state_next = bus.pslverr ? console_pkg::IDLE : console_pkg::UART_SETUP;
                end
            end
            console_pkg::UART_SETUP:  state_next = console_pkg::UART_ACCESS;
            console_pkg::UART_ACCESS: begin
                if (bus.pready) begin
                    state_next = console_pkg::IDLE;
                end
            end
            default: state_next = console_pkg::IDLE;
        endcase
    end

    // bus outputs decoded from state, stable over each transfer
    always_comb begin
        bus.psel    = (state != console_pkg::IDLE);
        bus.penable = (state == console_pkg::POLL_ACCESS) ||
                      (state == console_pkg::LED_ACCESS) ||
                      (state == console_pkg::UART_ACCESS);
        bus.pwrite  = (state == console_pkg::LED_SETUP) || (state == console_pkg::LED_ACCESS) ||
                      (state == console_pkg::UART_SETUP) || (state == console_pkg::UART_ACCESS);
        bus.pwdata  = {24'h000000, pending_char};
        case (state)
            console_pkg::LED_SETUP,
            console_pkg::LED_ACCESS:  bus.paddr = console_pkg::LED_ADDR;
            console_pkg::UART_SETUP,
            console_pkg::UART_ACCESS: bus.paddr = console_pkg::UART_DATA_ADDR;
            default:                  bus.paddr = console_pkg::UART_STAT_ADDR;
        endcase
    end

endmodule

// ==== rtl/scan_decoder.sv ====
module scan_decoder (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  console_pkg::scan_t  scan,
    input  logic                scan_valid,
    output console_pkg::ascii_t char,
    output logic                char_valid
);

    // prefix flags, live until the next plain code
    logic                brk_seen;
    logic                ext_seen;
    console_pkg::ascii_t mapped;
    logic                is_prefix;
    logic                emit;

    assign mapped = console_pkg::scan_to_ascii(scan);

    assign is_prefix = (scan == console_pkg::BREAK_CODE) ||
                       (scan == console_pkg::EXT_CODE);

    // only plain make codes of mapped keys
    assign emit = scan_valid && !is_prefix && !brk_seen && !ext_seen &&
                  (mapped != 8'h00);

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            brk_seen   <= 1'b0;
            ext_seen   <= 1'b0;
            char_valid <= 1'b0;
        end else begin
            char_valid <= emit;
            if (scan_valid) begin
                if (scan == console_pkg::BREAK_CODE) begin
                    brk_seen <= 1'b1;
                end else if (scan == console_pkg::EXT_CODE) begin
                    ext_seen <= 1'b1;
                end else begin
                    // code after a prefix is consumed here
                    brk_seen <= 1'b0;
                    ext_seen <= 1'b0;
                end
            end
        end
    end

    // character held until the next key
    always_ff @(posedge CLOCK_50) begin
        if (emit) begin
            char <= mapped;
        end
    end

endmodule

// ==== rtl/ps2_receiver.sv ====
module ps2_receiver (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    output console_pkg::scan_t  scan,
    output logic                scan_valid
);

    // two flop synchronizers, idle level is high
    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    // delayed copy for edge detect
    logic        clk_prev;
    logic        fall;
    // frame shifts in lsb first, start bit ends up in bit 0
    logic [10:0] frame;
    logic [10:0] frame_next;
    logic [3:0]  bit_cnt;
    logic        frame_ok;

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // keyboard drives data on its falling clock edge
    assign fall = clk_prev & ~clk_sync[1];

    // frame as it stands once the current bit is in
    assign frame_next = {dat_sync[1], frame[10:1]};

    // start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame_next[0] & frame_next[10] & (^frame_next[9:1]);

    // bit counter and valid pulse
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            bit_cnt    <= 4'd0;
            scan_valid <= 1'b0;
        end else begin
            scan_valid <= 1'b0;
            if (fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= 4'd0;
                    // bad frames just vanish
                    scan_valid <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // payload path
    always_ff @(posedge CLOCK_50) begin
        if (fall) begin
            frame <= frame_next;
            if (bit_cnt == 4'd10) begin
                scan <= frame_next[8:1];
            end
        end
    end

endmodule

// ==== rtl/apb_if.sv ====
interface apb_if;

    console_pkg::apb_addr_t paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    console_pkg::apb_data_t pwdata;
    console_pkg::apb_data_t prdata;
    logic                   pready;
    logic                   pslverr;

    // initiator side
    modport master (
        output paddr, psel, penable, pwrite, pwdata,
        input  prdata, pready, pslverr
    );

    // target side
    modport slave (
        input  paddr, psel, penable, pwrite, pwdata,
        output prdata, pready, pslverr
    );

endinterface

// ==== rtl/console_pkg.sv ====
package console_pkg;

    // bus and character widths
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [7:0]  ascii_t;
    typedef logic [7:0]  scan_t;

    // peripheral register map
    localparam apb_addr_t LED_ADDR       = 8'h00;
    localparam apb_addr_t UART_DATA_ADDR = 8'h10;
    localparam apb_addr_t UART_STAT_ADDR = 8'h14;

    // ps/2 set 2 prefixes
    localparam scan_t BREAK_CODE = 8'hF0;
    localparam scan_t EXT_CODE   = 8'hE0;

    // bus master sequence: status poll, led write, uart write
    typedef enum logic [2:0] {
        IDLE,
        POLL_SETUP,
        POLL_ACCESS,
        LED_SETUP,
        LED_ACCESS,
        UART_SETUP,
        UART_ACCESS
    } master_state_t;

    // set 2 make code to lower case ascii, 0 when unmapped
    function automatic ascii_t scan_to_ascii(scan_t code);
        case (code)
            8'h1C: return "a";
            8'h32: return "b";
            8'h21: return "c";
            8'h23: return "d";
            8'h24: return "e";
            8'h2B: return "f";
            8'h34: return "g";
            8'h33: return "h";
            8'h43: return "i";
            8'h3B: return "j";
            8'h42: return "k";
            8'h4B: return "l";
            8'h3A: return "m";
            8'h31: return "n";
            8'h44: return "o";
            8'h4D: return "p";
            8'h15: return "q";
            8'h2D: return "r";
            8'h1B: return "s";
            8'h2C: return "t";
            8'h3C: return "u";
            8'h2A: return "v";
            8'h1D: return "w";
            8'h22: return "x";
            8'h35: return "y";
            8'h1A: return "z";
            8'h45: return "0";
            8'h16: return "1";
            8'h1E: return "2";
            8'h26: return "3";
            8'h25: return "4";
            8'h2E: return "5";
            8'h36: return "6";
            8'h3D: return "7";
            8'h3E: return "8";
            8'h46: return "9";
            8'h29: return " ";
            // enter sends carriage return
            8'h5A: return 8'h0D;
            default: return 8'h00;
        endcase
    endfunction

endpackage
